// ==== include/aes_params.svh ====
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// block, round key and seed half width
`define AES_BLOCK_W    128

// one key schedule word
`define AES_WORD_W     32

// AES-256 cipher rounds
`define AES_ROUNDS     14

// round keys kept in the store, rounds plus initial whitening
`define AES_RK_NUM     15

// enough to address all round keys
`define AES_RK_ADDR_W  4

`endif

// ==== src/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

    `include "aes_params.svh"

    // host command on mod_en, held as a level
    typedef enum logic [1:0]
    {
        mode_encrypt = 2'd0,
        // decrypt and end codes are reserved, treated as unsupported
        mode_decrypt = 2'd1,
        mode_keygen  = 2'd2,
        mode_end     = 2'd3
    } mode_t;

    // device mode FSM
    typedef enum logic [2:0]
    {
        st_idle,
        st_chs_mod,
        st_seed,
        st_keygen,
        st_enc
    } dev_state_t;

    // one round key write into the store
    typedef struct packed
    {
        logic                      wr_en;
        logic [`AES_RK_ADDR_W-1:0] addr;
        logic [`AES_BLOCK_W-1:0]   data;
    } key_wr_t;

    // cipher result, valid for a single cycle
    typedef struct packed
    {
        logic                    valid;
        logic [`AES_BLOCK_W-1:0] data;
    } block_out_t;

endpackage

`default_nettype wire

// ==== src/aes_sbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_sbox
(
    input  wire [7:0]  byte_in,
    output logic [7:0] byte_out
);

    // forward S-box, entry 0x00 in the top byte
    localparam logic [2047:0] SBOX_TAB =
    {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // msb of entry n sits at bit 2047 - 8*n, which is {~n, 3'b111}
    assign byte_out = SBOX_TAB[{~byte_in, 3'b111} -: 8];

endmodule

`default_nettype wire

// ==== src/aes_key_expander.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_key_expander
(
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      start,
    input  wire [2*`AES_BLOCK_W-1:0] key,
    output aes_pkg::key_wr_t         key_wr,
    output logic                     done
);

    // window of the last eight schedule words, w0 in the top word
    logic [2*`AES_BLOCK_W-1:0] win_q;
    // index of the round key written this cycle
    logic [`AES_RK_ADDR_W-1:0] cnt_q;
    logic [7:0]                rcon_q;
    logic                      busy_q;
    logic                      next_even;
    logic                      last_key;
    logic [`AES_WORD_W-1:0]    temp;
    logic [`AES_WORD_W-1:0]    sub_w;
    logic [`AES_WORD_W-1:0]    mix_w;
    logic [`AES_WORD_W-1:0]    nw0;
    logic [`AES_WORD_W-1:0]    nw1;
    logic [`AES_WORD_W-1:0]    nw2;
    logic [`AES_WORD_W-1:0]    nw3;

    // key written now is odd, so the words being built belong to an even key
    assign next_even = cnt_q[0];
    assign last_key  = (cnt_q == `AES_RK_ADDR_W'(`AES_RK_NUM - 1));

    // RotWord only for even keys
    assign temp = next_even ? {win_q[23:0], win_q[31:24]} : win_q[`AES_WORD_W-1:0];

    genvar i;
    generate
        for (i = 0; i < 4; i++)
        begin : g_sub
            aes_sbox u_sbox
            (
                .byte_in  (temp[8*i +: 8]),
                .byte_out (sub_w[8*i +: 8])
            );
        end
    endgenerate

    assign mix_w = sub_w ^ (next_even ? {rcon_q, 24'h000000} : '0);

    // four new words, each chained on the one before
    assign nw0 = win_q[2*`AES_BLOCK_W-1 -: `AES_WORD_W] ^ mix_w;
    assign nw1 = win_q[2*`AES_BLOCK_W-1-`AES_WORD_W -: `AES_WORD_W] ^ nw0;
    assign nw2 = win_q[2*`AES_BLOCK_W-1-2*`AES_WORD_W -: `AES_WORD_W] ^ nw1;
    assign nw3 = win_q[2*`AES_BLOCK_W-1-3*`AES_WORD_W -: `AES_WORD_W] ^ nw2;

    // key 0 is the seed high half, written straight through during start
    always_comb
    begin
        key_wr.wr_en = start | busy_q;
        key_wr.addr  = start ? '0 : cnt_q;
        key_wr.data  = start ? key[2*`AES_BLOCK_W-1 -: `AES_BLOCK_W]
                             : win_q[`AES_BLOCK_W-1:0];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy_q <= 1'b0;
            done   <= 1'b0;
            cnt_q  <= '0;
            rcon_q <= 8'h00;
        end
        else
        begin
            done <= busy_q && last_key;
            if (start)
            begin
                busy_q <= 1'b1;
                cnt_q  <= `AES_RK_ADDR_W'(1);
                rcon_q <= 8'h01;
            end
            else if (busy_q)
            begin
                cnt_q <= cnt_q + 1'b1;
                // only seven rcon steps in AES-256, a plain shift never wraps
                if (next_even)
                begin
                    rcon_q <= {rcon_q[6:0], 1'b0};
                end
                if (last_key)
                begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // slide the window by one round key
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            win_q <= key;
        end
        else if (busy_q)
        begin
            win_q <= {win_q[`AES_BLOCK_W-1:0], nw0, nw1, nw2, nw3};
        end
    end

endmodule

`default_nettype wire

// ==== src/aes_round_key_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_round_key_ram
(
    input  wire                      clk,
    input  wire                      resetn,
    input  wire aes_pkg::key_wr_t    key_wr,
    input  wire                      clear,
    input  wire [`AES_RK_ADDR_W-1:0] rd_addr,
    output logic [`AES_BLOCK_W-1:0]  rd_data,
    output logic                     ready
);

    logic [`AES_BLOCK_W-1:0] mem [`AES_RK_NUM];

    always_ff @(posedge clk)
    begin
        if (key_wr.wr_en)
        begin
            mem[key_wr.addr] <= key_wr.data;
        end
    end

    // asynchronous read, the cipher uses the key in the same cycle
    assign rd_data = mem[rd_addr];

    // last round key written means the whole schedule is in place
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ready <= 1'b0;
        end
        else if (clear)
        begin
            ready <= 1'b0;
        end
        else if (key_wr.wr_en && key_wr.addr == `AES_RK_ADDR_W'(`AES_RK_NUM - 1))
        begin
            ready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/aes_cipher.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_cipher
(
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      start,
    input  wire [`AES_BLOCK_W-1:0]   block_in,
    output logic [`AES_RK_ADDR_W-1:0] rk_addr,
    input  wire [`AES_BLOCK_W-1:0]   rk_data,
    output aes_pkg::block_out_t      result
);

    logic [`AES_BLOCK_W-1:0]   state_q;
    logic [`AES_BLOCK_W-1:0]   sub_b;
    logic [`AES_BLOCK_W-1:0]   shift_b;
    logic [`AES_BLOCK_W-1:0]   mix_b;
    logic [`AES_BLOCK_W-1:0]   round_b;
    logic [`AES_RK_ADDR_W-1:0] rnd_q;
    logic                      busy_q;
    logic                      valid_q;
    logic                      last_rnd;

    // multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // SubBytes, byte n of the block at bits 127-8n
    genvar i;
    generate
        for (i = 0; i < 16; i++)
        begin : g_sbox
            aes_sbox u_sbox
            (
                .byte_in  (state_q[`AES_BLOCK_W-1-8*i -: 8]),
                .byte_out (sub_b[`AES_BLOCK_W-1-8*i -: 8])
            );
        end
    endgenerate

    // ShiftRows, row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shift_b[`AES_BLOCK_W-1-8*(r+4*c) -: 8] =
                    sub_b[`AES_BLOCK_W-1-8*(r+4*((c+r)%4)) -: 8];
            end
        end
    end

    // MixColumns, one column of four bytes at a time
    always_comb
    begin
        logic [7:0] a [4];
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                a[r] = shift_b[`AES_BLOCK_W-1-8*(r+4*c) -: 8];
            end
            mix_b[`AES_BLOCK_W-1-32*c -: 8]  = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
            mix_b[`AES_BLOCK_W-9-32*c -: 8]  = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
            mix_b[`AES_BLOCK_W-17-32*c -: 8] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
            mix_b[`AES_BLOCK_W-25-32*c -: 8] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        end
    end

    // final round skips MixColumns
    assign last_rnd = (rnd_q == `AES_RK_ADDR_W'(`AES_ROUNDS));
    assign round_b  = (last_rnd ? shift_b : mix_b) ^ rk_data;

    // key 0 while idle or starting, key of the current round while busy
    assign rk_addr = busy_q ? rnd_q : '0;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            rnd_q   <= '0;
        end
        else
        begin
            valid_q <= busy_q && last_rnd;
            if (start)
            begin
                busy_q <= 1'b1;
                rnd_q  <= `AES_RK_ADDR_W'(1);
            end
            else if (busy_q)
            begin
                if (last_rnd)
                begin
                    busy_q <= 1'b0;
                    rnd_q  <= '0;
                end
                else
                begin
                    rnd_q <= rnd_q + 1'b1;
                end
            end
        end
    end

    // initial AddRoundKey on start, then one full round per clock
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            state_q <= block_in ^ rk_data;
        end
        else if (busy_q)
        begin
            state_q <= round_b;
        end
    end

    assign result.valid = valid_q;
    assign result.data  = state_q;

endmodule

`default_nettype wire

// ==== src/aes_device.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_device
(
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     ctrl_data_in,
    input  wire aes_pkg::mode_t     mod_en,
    input  wire [`AES_BLOCK_W-1:0]  inp_device,
    input  wire [`AES_BLOCK_W-1:0]  seed,
    output logic [`AES_BLOCK_W-1:0] outp_device,
    output logic                    ctrl_data_out,
    output logic                    mod_decrease
);

    aes_pkg::dev_state_t       state_q;
    logic [`AES_BLOCK_W-1:0]   key_hi_q;
    logic [`AES_BLOCK_W-1:0]   key_lo_q;
    logic [`AES_BLOCK_W-1:0]   block_q;
    logic                      kg_start_q;
    logic                      enc_start_q;
    logic                      kg_done;
    logic                      rk_ready;
    logic                      take_hi;
    logic                      take_lo;
    logic                      take_blk;
    logic [`AES_RK_ADDR_W-1:0] rk_addr;
    logic [`AES_BLOCK_W-1:0]   rk_data;
    aes_pkg::key_wr_t          key_wr;
    aes_pkg::block_out_t       enc_res;

    // seed high half in mode select, low half one cycle later
    assign take_hi = (state_q == aes_pkg::st_chs_mod) && (mod_en == aes_pkg::mode_keygen);
    assign take_lo = (state_q == aes_pkg::st_seed) && (mod_en == aes_pkg::mode_keygen);
    // encrypt waits here until the round keys are stored
    assign take_blk = (state_q == aes_pkg::st_chs_mod) && (mod_en == aes_pkg::mode_encrypt)
                      && rk_ready;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q       <= aes_pkg::st_idle;
            mod_decrease  <= 1'b0;
            kg_start_q    <= 1'b0;
            enc_start_q   <= 1'b0;
            ctrl_data_out <= 1'b0;
            outp_device   <= '0;
        end
        else
        begin
            // acknowledge each accepted seed half or block
            mod_decrease  <= take_hi | take_lo | take_blk;
            kg_start_q    <= take_lo;
            enc_start_q   <= take_blk;
            ctrl_data_out <= enc_res.valid;
            if (enc_res.valid)
            begin
                outp_device <= enc_res.data;
            end

            case (state_q)
                aes_pkg::st_idle:
                begin
                    if (ctrl_data_in)
                    begin
                        state_q <= aes_pkg::st_chs_mod;
                    end
                end
                aes_pkg::st_chs_mod:
                begin
                    if (take_hi)
                    begin
                        state_q <= aes_pkg::st_seed;
                    end
                    else if (take_blk)
                    begin
                        state_q <= aes_pkg::st_enc;
                    end
                    // unsupported mode drops back without an ack
                    else if (mod_en != aes_pkg::mode_encrypt)
                    begin
                        state_q <= aes_pkg::st_idle;
                    end
                end
                aes_pkg::st_seed:
                begin
                    state_q <= take_lo ? aes_pkg::st_keygen : aes_pkg::st_idle;
                end
                aes_pkg::st_keygen:
                begin
                    if (kg_done)
                    begin
                        state_q <= aes_pkg::st_idle;
                    end
                end
                aes_pkg::st_enc:
                begin
                    if (enc_res.valid)
                    begin
                        state_q <= aes_pkg::st_idle;
                    end
                end
                default:
                begin
                    state_q <= aes_pkg::st_idle;
                end
            endcase
        end
    end

    // seed halves and plaintext
    always_ff @(posedge clk)
    begin
        if (take_hi)
        begin
            key_hi_q <= seed;
        end
        if (take_lo)
        begin
            key_lo_q <= seed;
        end
        if (take_blk)
        begin
            block_q <= inp_device;
        end
    end

    aes_key_expander u_key_expander
    (
        .clk    (clk),
        .resetn (resetn),
        .start  (kg_start_q),
        .key    ({key_hi_q, key_lo_q}),
        .key_wr (key_wr),
        .done   (kg_done)
    );

    // old round keys invalid from the moment a new expansion starts
    aes_round_key_ram u_rk_ram
    (
        .clk     (clk),
        .resetn  (resetn),
        .key_wr  (key_wr),
        .clear   (kg_start_q),
        .rd_addr (rk_addr),
        .rd_data (rk_data),
        .ready   (rk_ready)
    );

    aes_cipher u_cipher
    (
        .clk      (clk),
        .resetn   (resetn),
        .start    (enc_start_q),
        .block_in (block_q),
        .rk_addr  (rk_addr),
        .rk_data  (rk_data),
        .result   (enc_res)
    );

endmodule

`default_nettype wire

// ==== tb/aes_device_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_device_tb;

    // half period of the 4 ns clock
    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 16;
    // block ack to ctrl_data_out
    localparam int ENC_LATENCY  = 16;
    // encrypt held in mode select with no key
    localparam int IDLE_WAIT    = 40;
    localparam int ACK_TIMEOUT  = 60;
    // watchdog budget
    localparam int CYC_PER_VEC  = 80;
    localparam int CYC_BASE     = 200;

    logic                    clk;
    logic                    resetn;
    logic                    ctrl_data_in;
    aes_pkg::mode_t          mod_en;
    logic [`AES_BLOCK_W-1:0] inp_device;
    logic [`AES_BLOCK_W-1:0] seed;
    logic [`AES_BLOCK_W-1:0] outp_device;
    logic                    ctrl_data_out;
    logic                    mod_decrease;

    // known-answer vectors from the stim file
    logic [`AES_BLOCK_W-1:0] vec_hi [$];
    logic [`AES_BLOCK_W-1:0] vec_lo [$];
    logic [`AES_BLOCK_W-1:0] vec_pt [$];
    logic [`AES_BLOCK_W-1:0] vec_ct [$];
    int                      n_vec;
    bit                      vec_loaded;
    integer                  rnd_seed = 20;

    aes_device DUT
    (
        .clk           (clk),
        .resetn        (resetn),
        .ctrl_data_in  (ctrl_data_in),
        .mod_en        (mod_en),
        .inp_device    (inp_device),
        .seed          (seed),
        .outp_device   (outp_device),
        .ctrl_data_out (ctrl_data_out),
        .mod_decrease  (mod_decrease)
    );

    always #CLK_HALF clk = ~clk;

    // print the reason and end the run
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [`AES_BLOCK_W-1:0] exp,
                               input logic [`AES_BLOCK_W-1:0] act);
        if (exp !== act)
        begin
            stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // filler for inputs the device ignores
    function automatic logic [`AES_BLOCK_W-1:0] random_block();
        random_block = {$random(rnd_seed), $random(rnd_seed),
                        $random(rnd_seed), $random(rnd_seed)};
    endfunction

    task automatic read_vectors();
        integer                  fd;
        integer                  rc;
        string                   line;
        logic [`AES_BLOCK_W-1:0] hi;
        logic [`AES_BLOCK_W-1:0] lo;
        logic [`AES_BLOCK_W-1:0] pt;
        logic [`AES_BLOCK_W-1:0] ct;
        fd = $fopen("tb/aes_stim.txt", "r");
        if (fd == 0)
        begin
            stop_run("cannot open the vector file tb/aes_stim.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                rc = $fgets(line, fd);
                // skip comments and blank lines
                if (rc > 0 && line.len() > 1 && line[0] != "#")
                begin
                    rc = $sscanf(line, "%h %h %h %h", hi, lo, pt, ct);
                    if (rc == 4)
                    begin
                        vec_hi.push_back(hi);
                        vec_lo.push_back(lo);
                        vec_pt.push_back(pt);
                        vec_ct.push_back(ct);
                    end
                end
            end
            $fclose(fd);
            n_vec = vec_hi.size();
            if (n_vec == 0)
            begin
                stop_run("the vector file holds no vectors");
            end
            else
            begin
                vec_loaded = 1'b1;
            end
        end
    endtask

    // no ack and no done for a number of cycles
    task automatic hold_quiet(input string what, input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            inp_device = random_block();
            seed       = random_block();
            @(negedge clk);
            check_value({what, " mod_decrease"}, '0, 128'(mod_decrease));
            check_value({what, " ctrl_data_out"}, '0, 128'(ctrl_data_out));
        end
    endtask

    // returns at the falling edge where mod_decrease is seen high
    task automatic wait_ack(input string what);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < ACK_TIMEOUT)
        begin
            @(negedge clk);
            n++;
            seen = mod_decrease;
        end
        if (!seen)
        begin
            stop_run($sformatf("no acknowledge on mod_decrease for %s", what));
        end
    endtask

    // high half first and low half on the next cycle
    task automatic load_key(input int idx);
        ctrl_data_in = 1'b1;
        mod_en       = aes_pkg::mode_keygen;
        seed         = vec_hi[idx];
        inp_device   = random_block();
        wait_ack($sformatf("key %0d high half", idx));
        ctrl_data_in = 1'b0;
        seed         = vec_lo[idx];
        @(negedge clk);
        check_value($sformatf("key %0d low half ack", idx), 128'(1), 128'(mod_decrease));
        seed   = random_block();
        mod_en = aes_pkg::mode_encrypt;
        @(negedge clk);
        // exactly two ack pulses
        check_value($sformatf("key %0d ack count", idx), '0, 128'(mod_decrease));
    endtask

    task automatic encrypt_block(input int idx, input string name);
        int n;
        bit seen;
        ctrl_data_in = 1'b1;
        mod_en       = aes_pkg::mode_encrypt;
        inp_device   = vec_pt[idx];
        seed         = random_block();
        // waits out a running key expansion as well
        wait_ack(name);
        ctrl_data_in = 1'b0;
        inp_device   = random_block();
        n    = 0;
        seen = 1'b0;
        while (!seen && n < ACK_TIMEOUT)
        begin
            @(negedge clk);
            n++;
            seen = ctrl_data_out;
            // block ack is a single pulse
            check_value({name, " block ack width"}, '0, 128'(mod_decrease));
        end
        if (!seen)
        begin
            stop_run($sformatf("no ctrl_data_out strobe for %s", name));
        end
        else
        begin
            check_value({name, " latency"}, 128'(ENC_LATENCY), 128'(n));
            check_value({name, " ciphertext"}, vec_ct[idx], outp_device);
            @(negedge clk);
            check_value({name, " done width"}, '0, 128'(ctrl_data_out));
            check_value({name, " ciphertext held"}, vec_ct[idx], outp_device);
        end
    endtask

    // ends the run once the test time is clearly over
    initial
    begin
        wait (vec_loaded);
        repeat (n_vec * CYC_PER_VEC + CYC_BASE) @(posedge clk);
        stop_run("watchdog expired before the tests completed");
    end

    initial
    begin
        clk          = 1'b0;
        resetn       = 1'b0;
        ctrl_data_in = 1'b0;
        mod_en       = aes_pkg::mode_encrypt;
        inp_device   = '0;
        seed         = '0;
        read_vectors();

        // outputs quiet during reset
        repeat (RESET_CYCLES) @(negedge clk);
        check_value("reset outp_device", '0, outp_device);
        check_value("reset ctrl_data_out", '0, 128'(ctrl_data_out));
        check_value("reset mod_decrease", '0, 128'(mod_decrease));
        resetn = 1'b1;
        hold_quiet("after reset", 8);
        check_value("after reset outp_device", '0, outp_device);

        // encrypt with an empty key store waits in mode select
        ctrl_data_in = 1'b1;
        mod_en       = aes_pkg::mode_encrypt;
        hold_quiet("encrypt without key", IDLE_WAIT);
        load_key(0);

        // known answer and key reuse with a new key per vector
        for (int v = 0; v < n_vec; v++)
        begin
            if (v > 0)
            begin
                load_key(v);
            end
            encrypt_block(v, $sformatf("vector %0d", v));
            encrypt_block(v, $sformatf("vector %0d key reuse", v));
        end

        // unsupported decrypt code drops the device back to idle
        ctrl_data_in = 1'b1;
        mod_en       = aes_pkg::mode_decrypt;
        hold_quiet("decrypt command", 1);
        ctrl_data_in = 1'b0;
        hold_quiet("decrypt command", 1);
        // encrypt code would be taken only if still in mode select
        mod_en = aes_pkg::mode_encrypt;
        hold_quiet("after decrypt command", 20);
        check_value("outp_device after decrypt command", vec_ct[n_vec-1], outp_device);
        // still usable afterwards
        encrypt_block(n_vec - 1, "encrypt after decrypt command");

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/aes_stim.txt ====
# columns: seed high half, seed low half, plaintext, expected ciphertext
# all values 128-bit hex, one vector per line
000102030405060708090a0b0c0d0e0f 101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
603deb1015ca71be2b73aef0857d7781 1f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 dc95c078a2408989ad48a21492842087
603deb1015ca71be2b73aef0857d7781 1f352c073b6108d72d9810a30914dff4 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
603deb1015ca71be2b73aef0857d7781 1f352c073b6108d72d9810a30914dff4 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
603deb1015ca71be2b73aef0857d7781 1f352c073b6108d72d9810a30914dff4 f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7

// ==== aes_device.f ====
+incdir+include
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_key_expander.sv
src/aes_round_key_ram.sv
src/aes_cipher.sv
src/aes_device.sv
tb/aes_device_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the AES device testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
    && verilator --binary -Wno-fatal -f aes_device.f --top-module aes_device_tb \
        -o aes_device_sim \
    && ./obj_dir/aes_device_sim \
    || { echo "simulation run returned an error status"; exit 1; }
